/* hdl/core_defs.svh */
/*
 * Core-wide widths and latencies for the decode/execute slice.
 * MUL_CYCLES must be 2 or more, because the multiplier counts MUL_CYCLES-1 busy edges.
 */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Data path and instruction width
`define XLEN 32

// Register index width, 32 architectural registers
`define REG_ADDR_W 5

// Edges from multiply acceptance to registered product
`define MUL_CYCLES 4

// ADDI x0, x0, 0
`define NOP_WORD 32'h0000_0013

`endif

/* hdl/core_pkg.sv */
/*
 * Types passed between decode and execute.
 * The ALU_PASS encoding is zero, so a cleared control bundle is a bubble.
 */
`include "core_defs.svh"

package core_pkg;

  // ALU operation, 3 bits
  typedef enum logic [2:0] {
    ALU_PASS = 3'd0,
    ALU_ADD  = 3'd1,
    ALU_SUB  = 3'd2,
    ALU_AND  = 3'd3,
    ALU_OR   = 3'd4,
    ALU_MUL  = 3'd5
  } alu_op_e;

  // Decoded control, 9 bits
  typedef struct packed {
    logic    valid;
    alu_op_e alu_op;
    logic    alu_src_imm;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    branch;
  } ctrl_t;

  // Contents of the decode/execute pipeline register
  typedef struct packed {
    ctrl_t                  ctrl;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic [`XLEN-1:0]       imm;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       pc;
  } idex_t;

  // Registered execute result
  typedef struct packed {
    logic                   valid;
    logic [`XLEN-1:0]       result;
    logic [`XLEN-1:0]       store_data;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   reg_write;
    logic                   mem_read;
    logic                   mem_write;
    logic                   branch_taken;
    logic [`XLEN-1:0]       branch_target;
  } ex_result_t;

endpackage

/* hdl/instr_decoder.sv */
/*
 * Decodes ADD, SUB, AND, OR, MUL, ADDI, LW, SW and BEQ.
 * Anything else, the canonical NOP included, gives an all-zero control bundle.
 * ctrl.valid is always zero here; the top level supplies it.
 */
`timescale 1ns/1ps
`include "core_defs.svh"

module instr_decoder (
  input  logic [`XLEN-1:0]       instr,
  output core_pkg::ctrl_t        ctrl,
  output logic [`XLEN-1:0]       imm,
  output logic [`REG_ADDR_W-1:0] rs1,
  output logic [`REG_ADDR_W-1:0] rs2,
  output logic [`REG_ADDR_W-1:0] rd
);

  // Major opcodes in use
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // Source indices come straight from the fixed fields
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];

  // No destination unless the instruction writes back
  assign rd = ctrl.reg_write ? instr[11:7] : '0;

  always_comb
  begin
    ctrl = '0;
    imm  = '0;
    case (opcode)
      OPC_OP:
      begin
        ctrl.reg_write = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: ctrl.alu_op = core_pkg::ALU_ADD;
          10'b0100000_000: ctrl.alu_op = core_pkg::ALU_SUB;
          10'b0000000_111: ctrl.alu_op = core_pkg::ALU_AND;
          10'b0000000_110: ctrl.alu_op = core_pkg::ALU_OR;
          10'b0000001_000: ctrl.alu_op = core_pkg::ALU_MUL;
          default:         ctrl.reg_write = 1'b0;
        endcase
      end
      OPC_OP_IMM:
        // ADDI only; the canonical NOP stays a bubble
        if (funct3 == 3'b000 && instr != `NOP_WORD)
        begin
          ctrl.alu_op      = core_pkg::ALU_ADD;
          ctrl.alu_src_imm = 1'b1;
          ctrl.reg_write   = 1'b1;
          imm              = {{20{instr[31]}}, instr[31:20]};
        end
      OPC_LOAD:
        if (funct3 == 3'b010)
        begin
          // LW, address is rs1 + I immediate
          ctrl.alu_op      = core_pkg::ALU_ADD;
          ctrl.alu_src_imm = 1'b1;
          ctrl.reg_write   = 1'b1;
          ctrl.mem_read    = 1'b1;
          imm              = {{20{instr[31]}}, instr[31:20]};
        end
      OPC_STORE:
        if (funct3 == 3'b010)
        begin
          // SW, S immediate is split across two fields
          ctrl.alu_op      = core_pkg::ALU_ADD;
          ctrl.alu_src_imm = 1'b1;
          ctrl.mem_write   = 1'b1;
          imm              = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        end
      OPC_BRANCH:
        if (funct3 == 3'b000)
        begin
          // BEQ, B immediate is always even
          ctrl.alu_op = core_pkg::ALU_SUB;
          ctrl.branch = 1'b1;
          imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        end
      default:
        ctrl = '0;
    endcase
  end

endmodule

/* hdl/register_file.sv */
/*
 * 32 x XLEN register file, two combinational reads and one write.
 * Writes land at the clock edge with no bypass to the read ports.
 */
`timescale 1ns/1ps
`include "core_defs.svh"

module register_file (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`REG_ADDR_W-1:0] rs1,
  input  logic [`REG_ADDR_W-1:0] rs2,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data,
  input  logic                   wb_en,
  input  logic [`REG_ADDR_W-1:0] wb_rd,
  input  logic [`XLEN-1:0]       wb_data
);

  localparam int NUM_REGS = 2 ** `REG_ADDR_W;

  logic [`XLEN-1:0] regs [NUM_REGS];

  // Whole file clears on reset
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      regs <= '{default: '0};
    else if (wb_en && wb_rd != '0)
      // x0 never gets written, so it keeps reading zero
      regs[wb_rd] <= wb_data;
  end

  // Asynchronous read ports
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

/* hdl/decode_registers.sv */
/*
 * Decode/execute pipeline register.
 * flush wins over stall and loads a bubble; stall holds the current entry.
 */
`timescale 1ns/1ps
`include "core_defs.svh"

module decode_registers (
  input  logic            clk,
  input  logic            rst_n,
  input  core_pkg::idex_t idex_in,
  input  logic            stall,
  input  logic            flush,
  output core_pkg::idex_t idex_out
);

  core_pkg::ctrl_t        ctrl_q;
  logic [`XLEN-1:0]       rs1_q;
  logic [`XLEN-1:0]       rs2_q;
  logic [`XLEN-1:0]       imm_q;
  logic [`REG_ADDR_W-1:0] rd_q;
  logic [`XLEN-1:0]       pc_q;

  // Control bits, bubble clears valid, write enable, branch and memory strobes
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      ctrl_q <= '0;
    else if (flush)
      ctrl_q <= '0;
    else if (!stall)
      ctrl_q <= idex_in.ctrl;
  end

  // Operand payload
  always_ff @(posedge clk)
  begin
    if (flush)
    begin
      rs1_q <= '0;
      rs2_q <= '0;
      rd_q  <= '0;
    end
    else if (!stall)
    begin
      rs1_q <= idex_in.rs1_data;
      rs2_q <= idex_in.rs2_data;
      imm_q <= idex_in.imm;
      rd_q  <= idex_in.rd;
      pc_q  <= idex_in.pc;
    end
  end

  assign idex_out = '{
    ctrl:     ctrl_q,
    rs1_data: rs1_q,
    rs2_data: rs2_q,
    imm:      imm_q,
    rd:       rd_q,
    pc:       pc_q
  };

endmodule

/* hdl/alu_unit.sv */
/*
 * Execute stage with a registered result, one cycle for all ops but MUL.
 * MUL holds stall high for MUL_CYCLES-1 edges and returns the low XLEN bits.
 * Entries with no write-back, memory or branch effect give no result.
 */
`timescale 1ns/1ps
`include "core_defs.svh"

module alu_unit (
  input  logic                 clk,
  input  logic                 rst_n,
  input  core_pkg::idex_t      idex,
  output logic                 stall,
  output core_pkg::ex_result_t ex_out
);

  localparam int CNT_W = $clog2(`MUL_CYCLES);

  logic [`XLEN-1:0]       op_b;
  logic [`XLEN-1:0]       alu_res;
  logic [2*`XLEN-1:0]     product;
  logic [`XLEN-1:0]       mul_a;
  logic [`XLEN-1:0]       mul_b;
  logic [`REG_ADDR_W-1:0] mul_rd;
  logic [CNT_W-1:0]       mul_cnt;
  logic                   active;
  logic                   accept;
  logic                   is_mul;

  // Second operand, immediate or rs2
  assign op_b = idex.ctrl.alu_src_imm ? idex.imm : idex.rs2_data;

  // Bubbles and zero bundles have no visible effect
  assign active = idex.ctrl.valid & (idex.ctrl.reg_write | idex.ctrl.mem_read |
                                     idex.ctrl.mem_write | idex.ctrl.branch);
  assign accept = active & ~stall;
  assign is_mul = idex.ctrl.alu_op == core_pkg::ALU_MUL;

  // Multiplier works from latched operands over several cycles
  assign product = mul_a * mul_b;

  always_comb
  begin
    case (idex.ctrl.alu_op)
      core_pkg::ALU_ADD: alu_res = idex.rs1_data + op_b;
      core_pkg::ALU_SUB: alu_res = idex.rs1_data - op_b;
      core_pkg::ALU_AND: alu_res = idex.rs1_data & op_b;
      core_pkg::ALU_OR:  alu_res = idex.rs1_data | op_b;
      default:           alu_res = op_b;
    endcase
  end

  // Operand capture when a MUL is accepted
  always_ff @(posedge clk)
  begin
    if (accept && is_mul)
    begin
      mul_a  <= idex.rs1_data;
      mul_b  <= op_b;
      mul_rd <= idex.rd;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      stall   <= 1'b0;
      mul_cnt <= '0;
      ex_out  <= '0;
    end
    else
    begin
      // Strobes pulse for a single cycle
      ex_out.valid        <= 1'b0;
      ex_out.reg_write    <= 1'b0;
      ex_out.mem_read     <= 1'b0;
      ex_out.mem_write    <= 1'b0;
      ex_out.branch_taken <= 1'b0;
      if (stall)
      begin
        if (mul_cnt == CNT_W'(1))
        begin
          // Product done, release stall with the result
          stall             <= 1'b0;
          ex_out.valid      <= 1'b1;
          ex_out.result     <= product[`XLEN-1:0];
          ex_out.store_data <= mul_b;
          ex_out.rd         <= mul_rd;
          ex_out.reg_write  <= 1'b1;
        end
        else
          mul_cnt <= mul_cnt - 1'b1;
      end
      else if (accept && is_mul)
      begin
        stall   <= 1'b1;
        mul_cnt <= CNT_W'(`MUL_CYCLES - 1);
      end
      else if (accept)
      begin
        ex_out.valid         <= 1'b1;
        // Also the LW/SW address
        ex_out.result        <= alu_res;
        ex_out.store_data    <= idex.rs2_data;
        ex_out.rd            <= idex.rd;
        ex_out.reg_write     <= idex.ctrl.reg_write;
        ex_out.mem_read      <= idex.ctrl.mem_read;
        ex_out.mem_write     <= idex.ctrl.mem_write;
        ex_out.branch_taken  <= idex.ctrl.branch & (idex.rs1_data == idex.rs2_data);
        ex_out.branch_target <= idex.pc + idex.imm;
      end
    end
  end

endmodule

/* hdl/decode_execute.sv */
/*
 * Decode and execute slice of a small in-order core.
 * No forwarding or hazard checks; instr is ignored while stall is high.
 */
`timescale 1ns/1ps
`include "core_defs.svh"

module decode_execute (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`XLEN-1:0]       instr,
  input  logic [`XLEN-1:0]       pc,
  input  logic                   instr_valid,
  input  logic                   flush,
  input  logic                   wb_en,
  input  logic [`REG_ADDR_W-1:0] wb_rd,
  input  logic [`XLEN-1:0]       wb_data,
  output core_pkg::ex_result_t   ex_out,
  output logic                   stall
);

  core_pkg::ctrl_t        dec_ctrl;
  logic [`XLEN-1:0]       dec_imm;
  logic [`REG_ADDR_W-1:0] dec_rs1;
  logic [`REG_ADDR_W-1:0] dec_rs2;
  logic [`REG_ADDR_W-1:0] dec_rd;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;
  core_pkg::idex_t        idex_in;
  core_pkg::idex_t        idex_q;

  instr_decoder u_instr_decoder (
    .instr (instr),
    .ctrl  (dec_ctrl),
    .imm   (dec_imm),
    .rs1   (dec_rs1),
    .rs2   (dec_rs2),
    .rd    (dec_rd)
  );

  register_file u_register_file (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (dec_rs1),
    .rs2      (dec_rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb_en    (wb_en),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

  // Decoded bundle, valid taken from the fetch strobe
  assign idex_in = '{
    ctrl: '{
      valid:       instr_valid,
      alu_op:      dec_ctrl.alu_op,
      alu_src_imm: dec_ctrl.alu_src_imm,
      reg_write:   dec_ctrl.reg_write,
      mem_read:    dec_ctrl.mem_read,
      mem_write:   dec_ctrl.mem_write,
      branch:      dec_ctrl.branch
    },
    rs1_data: rs1_data,
    rs2_data: rs2_data,
    imm:      dec_imm,
    rd:       dec_rd,
    pc:       pc
  };

  decode_registers u_decode_registers (
    .clk      (clk),
    .rst_n    (rst_n),
    .idex_in  (idex_in),
    .stall    (stall),
    .flush    (flush),
    .idex_out (idex_q)
  );

  alu_unit u_alu_unit (
    .clk    (clk),
    .rst_n  (rst_n),
    .idex   (idex_q),
    .stall  (stall),
    .ex_out (ex_out)
  );

endmodule

/* testbench/tb_decode_execute.sv */
/*
 * Directed tests for the decode/execute slice, inputs driven on the falling edge.
 * Register contents come only from the write-back port and are mirrored in a shadow array.
 * Expected values follow the ISA rules; the first mismatch ends the run.
 */
`timescale 1ns/1ps
`include "core_defs.svh"

module tb_decode_execute;

  localparam int TIMEOUT_CYCLES = 50;

  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic [`XLEN-1:0]       instr;
  logic [`XLEN-1:0]       pc;
  logic                   instr_valid;
  logic                   flush;
  logic                   wb_en;
  logic [`REG_ADDR_W-1:0] wb_rd;
  logic [`XLEN-1:0]       wb_data;
  core_pkg::ex_result_t   ex_out;
  logic                   stall;

  // Mirror of the register file
  logic [`XLEN-1:0] shadow [32];
  integer           seed;

  decode_execute u_decode_execute (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr       (instr),
    .pc          (pc),
    .instr_valid (instr_valid),
    .flush       (flush),
    .wb_en       (wb_en),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .ex_out      (ex_out),
    .stall       (stall)
  );

  // 10 ns clock
  always #5 clk = ~clk;

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_equal(input string what, input logic [`XLEN-1:0] got,
                             input logic [`XLEN-1:0] expected);
    if (got !== expected)
    begin
      $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, expected);
      abort_run();
    end
  endtask

  function automatic logic [`XLEN-1:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [`XLEN-1:0] encode_i(input logic [6:0] opc, input logic [11:0] imm,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
    return {imm, rs1, f3, rd, opc};
  endfunction

  // SW, immediate split into [11:5] and [4:0]
  function automatic logic [`XLEN-1:0] encode_s(input logic [11:0] imm, input logic [4:0] rs2,
                                                input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  // BEQ, bit 0 of the offset is implied
  function automatic logic [`XLEN-1:0] encode_b(input logic [12:0] imm, input logic [4:0] rs2,
                                                input logic [4:0] rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
  endfunction

  task automatic write_reg(input logic [4:0] rd, input logic [`XLEN-1:0] data);
    wb_en   = 1'b1;
    wb_rd   = rd;
    wb_data = data;
    @(negedge clk);
    wb_en = 1'b0;
    // x0 stays zero in the model too
    if (rd != 5'd0)
      shadow[rd] = data;
  endtask

  // Offer one instruction, hold it through any stall, return after its capture edge
  task automatic issue(input logic [`XLEN-1:0] word, input logic [`XLEN-1:0] pc_val);
    int waited;
    instr       = word;
    pc          = pc_val;
    instr_valid = 1'b1;
    waited      = 0;
    while (stall)
    begin
      if (waited >= TIMEOUT_CYCLES)
      begin
        $display("Timeout: stall never fell while an instruction was waiting");
        abort_run();
      end
      @(negedge clk);
      waited++;
    end
    @(negedge clk);
    instr_valid = 1'b0;
  endtask

  task automatic wait_for_result(output int edges);
    edges = 1;
    @(negedge clk);
    while (!ex_out.valid)
    begin
      if (edges >= TIMEOUT_CYCLES)
      begin
        $display("Timeout: no valid result appeared on ex_out");
        abort_run();
      end
      @(negedge clk);
      edges++;
    end
  endtask

  task automatic execute(input logic [`XLEN-1:0] word, input logic [`XLEN-1:0] pc_val);
    int edges;
    issue(word, pc_val);
    wait_for_result(edges);
    // Single-cycle ops appear one edge after capture
    check_equal("result latency", edges, 1);
  endtask

  task automatic expect_no_result(input int cycles);
    int c;
    for (c = 0; c < cycles; c++)
    begin
      @(negedge clk);
      check_equal("valid with nothing to execute", ex_out.valid, 1'b0);
    end
  endtask

  task automatic check_write_result(input string what, input logic [`XLEN-1:0] result,
                                    input logic [4:0] rd);
    check_equal({what, " valid"}, ex_out.valid, 1'b1);
    check_equal({what, " result"}, ex_out.result, result);
    check_equal({what, " rd"}, ex_out.rd, rd);
    check_equal({what, " reg_write"}, ex_out.reg_write, 1'b1);
  endtask

  task automatic test_reset_writeback();
    int r;
    check_equal("valid after reset", ex_out.valid, 1'b0);
    check_equal("stall after reset", stall, 1'b0);
    check_equal("reg_write after reset", ex_out.reg_write, 1'b0);
    check_equal("mem_read after reset", ex_out.mem_read, 1'b0);
    check_equal("mem_write after reset", ex_out.mem_write, 1'b0);
    check_equal("branch_taken after reset", ex_out.branch_taken, 1'b0);
    for (r = 1; r < 9; r++)
      write_reg(r, $random(seed));
    write_reg(5'd0, $random(seed));
    // ADDI x(20+r), x(r), 0 reads each register back
    for (r = 0; r < 9; r++)
    begin
      execute(encode_i(OPC_OP_IMM, 12'h000, r, 3'b000, 20 + r), 32'h40 + 4 * r);
      check_write_result("readback", shadow[r], 20 + r);
    end
  endtask

  task automatic test_r_type();
    int          i;
    logic [31:0] expected [4];
    logic [31:0] words [4];
    write_reg(5'd10, $random(seed));
    write_reg(5'd11, $random(seed));
    expected[0] = shadow[10] + shadow[11];
    expected[1] = shadow[10] - shadow[11];
    expected[2] = shadow[10] & shadow[11];
    expected[3] = shadow[10] | shadow[11];
    words[0]    = encode_r(7'b0000000, 5'd11, 5'd10, 3'b000, 5'd12);
    words[1]    = encode_r(7'b0100000, 5'd11, 5'd10, 3'b000, 5'd13);
    words[2]    = encode_r(7'b0000000, 5'd11, 5'd10, 3'b111, 5'd14);
    words[3]    = encode_r(7'b0000000, 5'd11, 5'd10, 3'b110, 5'd15);
    issue(words[0], 32'h100);
    check_equal("valid at capture edge", ex_out.valid, 1'b0);
    // Back to back, each result one edge behind its capture
    for (i = 1; i < 4; i++)
    begin
      issue(words[i], 32'h100 + 4 * i);
      check_write_result("R-type", expected[i-1], 12 + i - 1);
    end
    @(negedge clk);
    check_write_result("R-type", expected[3], 5'd15);
    @(negedge clk);
    check_equal("valid pulse width", ex_out.valid, 1'b0);
  endtask

  task automatic test_immediate();
    int          k;
    logic [11:0] imm12 [3];
    imm12[0] = 12'hFFF;
    imm12[1] = 12'h800;
    imm12[2] = 12'hFDB;
    for (k = 0; k < 3; k++)
    begin
      execute(encode_i(OPC_OP_IMM, imm12[k], 5'd1, 3'b000, 5'd21), 32'h180);
      check_write_result("ADDI", shadow[1] + {{20{imm12[k][11]}}, imm12[k]}, 5'd21);
    end
    // Undefined opcode, unsupported funct3 and the canonical NOP
    issue(32'hFFFF_FFFF, 32'h190);
    expect_no_result(4);
    issue(encode_r(7'b0000000, 5'd2, 5'd1, 3'b010, 5'd5), 32'h194);
    expect_no_result(4);
    issue(`NOP_WORD, 32'h198);
    expect_no_result(4);
  endtask

  task automatic test_multiply();
    int          edges;
    logic [63:0] product;
    write_reg(5'd16, $random(seed));
    write_reg(5'd17, $random(seed));
    product = {32'b0, shadow[16]} * {32'b0, shadow[17]};
    issue(encode_r(7'b0000001, 5'd17, 5'd16, 3'b000, 5'd18), 32'h200);
    edges = 1;
    @(negedge clk);
    while (!ex_out.valid)
    begin
      check_equal("stall during MUL", stall, 1'b1);
      if (edges >= TIMEOUT_CYCLES)
      begin
        $display("Timeout: MUL result never appeared");
        abort_run();
      end
      @(negedge clk);
      edges++;
    end
    check_equal("MUL latency", edges, `MUL_CYCLES);
    check_equal("stall with MUL result", stall, 1'b0);
    check_write_result("MUL", product[31:0], 5'd18);

    // MUL again, with an ADD offered once execute is busy
    issue(encode_r(7'b0000001, 5'd17, 5'd16, 3'b000, 5'd18), 32'h210);
    @(negedge clk);
    check_equal("stall after MUL accept", stall, 1'b1);
    fork
      issue(encode_r(7'b0000000, 5'd11, 5'd10, 3'b000, 5'd19), 32'h214);
      begin
        // Counted from the accept edge here
        wait_for_result(edges);
        check_equal("MUL latency behind stall", edges, `MUL_CYCLES - 1);
        check_write_result("MUL", product[31:0], 5'd18);
      end
    join
    wait_for_result(edges);
    check_equal("ADD after MUL latency", edges, 1);
    check_write_result("ADD after MUL", shadow[10] + shadow[11], 5'd19);
  endtask

  task automatic test_memory_branch();
    logic [11:0] off;
    logic [12:0] boff;
    off = $random(seed);
    execute(encode_i(OPC_LOAD, off, 5'd1, 3'b010, 5'd22), 32'h300);
    check_write_result("LW", shadow[1] + {{20{off[11]}}, off}, 5'd22);
    check_equal("LW mem_read", ex_out.mem_read, 1'b1);
    check_equal("LW mem_write", ex_out.mem_write, 1'b0);
    execute(encode_s(off, 5'd2, 5'd1), 32'h304);
    check_equal("SW address", ex_out.result, shadow[1] + {{20{off[11]}}, off});
    check_equal("SW store_data", ex_out.store_data, shadow[2]);
    check_equal("SW mem_write", ex_out.mem_write, 1'b1);
    check_equal("SW mem_read", ex_out.mem_read, 1'b0);
    check_equal("SW reg_write", ex_out.reg_write, 1'b0);
    // x3 equal to x1, x4 never equal
    write_reg(5'd3, shadow[1]);
    write_reg(5'd4, ~shadow[1]);
    boff = 13'h1FF0;
    execute(encode_b(boff, 5'd3, 5'd1), 32'h400);
    check_equal("BEQ taken", ex_out.branch_taken, 1'b1);
    check_equal("BEQ target", ex_out.branch_target, 32'h400 + {{19{boff[12]}}, boff});
    check_equal("BEQ reg_write", ex_out.reg_write, 1'b0);
    boff = 13'h0100;
    execute(encode_b(boff, 5'd4, 5'd1), 32'h404);
    check_equal("BEQ not taken", ex_out.branch_taken, 1'b0);
    check_equal("BEQ target", ex_out.branch_target, 32'h404 + {{19{boff[12]}}, boff});
  endtask

  task automatic test_flush();
    instr       = encode_r(7'b0000000, 5'd11, 5'd10, 3'b000, 5'd23);
    pc          = 32'h500;
    instr_valid = 1'b1;
    flush       = 1'b1;
    @(negedge clk);
    instr_valid = 1'b0;
    flush       = 1'b0;
    expect_no_result(3);
    execute(encode_r(7'b0000000, 5'd11, 5'd10, 3'b000, 5'd24), 32'h504);
    check_write_result("ADD after flush", shadow[10] + shadow[11], 5'd24);
  endtask

  initial
  begin : main_sequence
    int r;
    seed        = 32'h6151;
    rst_n       = 1'b0;
    instr       = `NOP_WORD;
    pc          = '0;
    instr_valid = 1'b0;
    flush       = 1'b0;
    wb_en       = 1'b0;
    wb_rd       = '0;
    wb_data     = '0;
    for (r = 0; r < 32; r++)
      shadow[r] = '0;
    // Four rising edges in reset
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    test_reset_writeback();
    test_r_type();
    test_immediate();
    test_multiply();
    test_memory_branch();
    test_flush();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* project.f */
+incdir+hdl
hdl/core_pkg.sv
hdl/instr_decoder.sv
hdl/register_file.sv
hdl/decode_registers.sv
hdl/alu_unit.sv
hdl/decode_execute.sv
testbench/tb_decode_execute.sv

/* Bender.yml */
package:
  name: decode_execute

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/core_pkg.sv
      - hdl/instr_decoder.sv
      - hdl/register_file.sv
      - hdl/decode_registers.sv
      - hdl/alu_unit.sv
      - hdl/decode_execute.sv
      - target: test
        files:
          - testbench/tb_decode_execute.sv
